// File: verilog/gem_macros.svh
`ifndef GEM_MACROS_SVH
`define GEM_MACROS_SVH

// ------------------------------------------------------------
// frame geometry
// ------------------------------------------------------------
`define GEM_NUM_CLUSTERS   4   // clusters per gem frame
`define GEM_CLUSTER_BITS   14  // cnt + adr
`define GEM_ADR_BITS       11  // pad address
`define GEM_CNT_BITS       3   // cluster size count
`define GEM_HALF_BITS      7   // odd parity group width

// ------------------------------------------------------------
// ram depths and axi4-lite register map
// ------------------------------------------------------------
`define GEM_RAW_ADR_BITS   11  // 2048 raw hit entries
`define GEM_DEBUG_ADR_BITS 10  // 1024 capture entries
`define GEM_AXI_ADDR_BITS  4
`define GEM_AXI_DATA_BITS  32
`define GEM_REG_CTRL       4'h0  // write only, rearm and parity clear
`define GEM_REG_STATUS     4'h4  // capture state and sticky parity
`define GEM_REG_RADR       4'h8  // debug read address and cluster select
`define GEM_REG_RDATA      4'hC  // selected debug cluster

`endif

// File: verilog/gem_pkg.sv
`default_nettype none
`include "gem_macros.svh"

package gem_pkg;

  typedef struct packed {
    logic [`GEM_CNT_BITS-1:0] cnt;  // upper bits, cluster size
    logic [`GEM_ADR_BITS-1:0] adr;  // lower bits, pad address
  } gem_cluster_t;

  typedef gem_cluster_t [`GEM_NUM_CLUSTERS-1:0] gem_frame_t;  // cluster 0 in the low bits
  typedef logic [1:0] gem_cluster_sel_t;

  typedef enum logic [1:0] {
    capture_idle    = 2'd0,  // armed, waiting for a valid cluster
    capture_filling = 2'd1,  // writing the debug ram
    capture_full    = 2'd2   // holding for readout
  } capture_state_t;

  typedef struct packed {
    logic [`GEM_AXI_ADDR_BITS-1:0]   awaddr;
    logic                            awvalid;
    logic [`GEM_AXI_DATA_BITS-1:0]   wdata;
    logic [`GEM_AXI_DATA_BITS/8-1:0] wstrb;
    logic                            wvalid;
    logic                            bready;
    logic [`GEM_AXI_ADDR_BITS-1:0]   araddr;
    logic                            arvalid;
    logic                            rready;
  } axil_req_t;

  typedef struct packed {
    logic                          awready;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic [`GEM_AXI_DATA_BITS-1:0] rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          arready;
  } axil_rsp_t;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // cluster is valid unless both top address bits are set
  function automatic logic cluster_valid(gem_cluster_t c);
    return !(c.adr[`GEM_ADR_BITS-1 -: 2] == 2'b11);
  endfunction

  // odd parity per 7-bit half, bit 1 covers the upper half
  function automatic logic [1:0] cluster_parity(gem_cluster_t c);
    logic [`GEM_CLUSTER_BITS-1:0] bits;
    bits = c;
    return {~(^bits[`GEM_CLUSTER_BITS-1:`GEM_HALF_BITS]), ~(^bits[`GEM_HALF_BITS-1:0])};
  endfunction

endpackage

`default_nettype wire

// File: verilog/gem_frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "gem_macros.svh"

module gem_frame_decoder (
  input  logic                         clock,
  input  logic                         reset,
  input  gem_pkg::gem_frame_t          gem_frame,  // raw frame, new every clock
  output gem_pkg::gem_frame_t          clusters,   // registered frame
  output logic [`GEM_NUM_CLUSTERS-1:0] vpf,        // per cluster valid flags
  output logic                         has_data,   // any cluster valid
  output logic                         nonzero     // any frame bit set
);

  import gem_pkg::*;

  logic [`GEM_NUM_CLUSTERS-1:0] vpf_next;  // valid flags of the incoming frame

  // ------------------------------------------------------------
  // address prefix check
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `GEM_NUM_CLUSTERS; i++) begin
      vpf_next[i] = cluster_valid(gem_frame[i]);  // prefix 11 marks an empty slot
    end
  end

  // ------------------------------------------------------------
  // one stage of registers, all outputs line up
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      clusters <= '0;
      vpf      <= '0;
      has_data <= 1'b0;
      nonzero  <= 1'b0;
    end else begin
      clusters <= gem_frame;
      vpf      <= vpf_next;
      has_data <= |vpf_next;   // capture trigger
      nonzero  <= |gem_frame;  // or of all 56 bits
    end
  end

endmodule

`default_nettype wire

// File: verilog/gem_hit_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "gem_macros.svh"

module gem_hit_ram #(
  parameter int ADR_BITS = `GEM_RAW_ADR_BITS  // depth is 2**ADR_BITS frames
) (
  input  logic                      clock,
  input  logic                      wen,         // write whole frame
  input  logic [ADR_BITS-1:0]       wadr,
  input  gem_pkg::gem_frame_t       wdata,
  input  logic [ADR_BITS-1:0]       radr,
  input  gem_pkg::gem_cluster_sel_t rsel,        // cluster 0-3 of the read frame
  output gem_pkg::gem_cluster_t     rdata,       // one cycle after radr and rsel
  output logic                      parity_err   // either half mismatched
);

  import gem_pkg::*;

  localparam int DEPTH = 2 ** ADR_BITS;

  typedef logic [`GEM_NUM_CLUSTERS-1:0][1:0] frame_par_t;  // two parity bits per cluster

  gem_frame_t data_mem [DEPTH];  // cluster payload
  frame_par_t par_mem  [DEPTH];  // stored half parity
  frame_par_t wpar;              // parity of the write frame
  logic [1:0] rpar;              // stored parity of the read cluster

  // ------------------------------------------------------------
  // write side, parity generated per half
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `GEM_NUM_CLUSTERS; i++) begin
      wpar[i] = cluster_parity(wdata[i]);
    end
  end

  always_ff @(posedge clock) begin
    if (wen) begin
      data_mem[wadr] <= wdata;
      par_mem[wadr]  <= wpar;
    end
  end

  // ------------------------------------------------------------
  // read side, select registered together with the data
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    rdata <= data_mem[radr][rsel];  // cluster chosen at read time
    rpar  <= par_mem[radr][rsel];   // its stored parity
  end

  // recompute on the read data and compare both halves
  assign parity_err = |(rpar ^ cluster_parity(rdata));

endmodule

`default_nettype wire

// File: verilog/gem_capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "gem_macros.svh"

module gem_capture_ctrl (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           has_data,  // decoded frame holds a valid cluster
  input  logic                           rearm,     // one cycle pulse from the csr
  output gem_pkg::capture_state_t        state,
  output logic                           wen,       // debug ram write enable
  output logic [`GEM_DEBUG_ADR_BITS-1:0] wadr       // debug ram write address
);

  import gem_pkg::*;

  localparam logic [`GEM_DEBUG_ADR_BITS-1:0] LAST_ADR = '1;  // entry 1023

  // ------------------------------------------------------------
  // arm, fill, hold
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= capture_idle;
      wadr  <= '0;
    end else begin
      case (state)
        capture_idle: begin
          wadr <= '0;  // fill always starts at entry 0
          if (has_data)
            state <= capture_filling;
        end
        capture_filling: begin
          wadr <= wadr + 1'b1;  // one frame per clock
          if (wadr == LAST_ADR)
            state <= capture_full;
        end
        capture_full: begin
          if (rearm)  // only honoured once the buffer is full
            state <= capture_idle;
        end
        default: state <= capture_idle;
      endcase
    end
  end

  // the trigger frame itself is not stored, entry 0 is the next one
  assign wen = (state == capture_filling);

endmodule

`default_nettype wire

// File: verilog/gem_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "gem_macros.svh"

module gem_csr (
  input  logic                           clock,
  input  logic                           reset,
  input  gem_pkg::axil_req_t             axil_req,
  output gem_pkg::axil_rsp_t             axil_rsp,
  input  gem_pkg::capture_state_t        capture_state,
  input  gem_pkg::gem_cluster_t          debug_rdata,       // selected debug cluster
  input  logic                           debug_parity_err,  // parity of debug_rdata
  output logic                           rearm,             // one cycle pulse
  output logic [`GEM_DEBUG_ADR_BITS-1:0] debug_radr,
  output gem_pkg::gem_cluster_sel_t      debug_rsel
);

  import gem_pkg::*;

  logic                          aw_ready;       // awready and wready together
  logic                          b_valid;
  logic [1:0]                    b_resp;
  logic                          ar_ready;
  logic                          r_valid;
  logic [1:0]                    r_resp;
  logic [`GEM_AXI_DATA_BITS-1:0] r_data;
  logic                          parity_sticky;  // status bit 8
  logic                          wr_fire;        // write handshake this cycle
  logic                          rd_fire;        // read address handshake this cycle
  logic                          wr_ctrl;
  logic                          wr_radr;
  logic [`GEM_AXI_DATA_BITS-1:0] rd_word;        // read mux output
  logic [1:0]                    rd_resp;

  assign wr_fire = aw_ready && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = ar_ready && axil_req.arvalid;
  assign wr_ctrl = (axil_req.awaddr == `GEM_REG_CTRL);
  assign wr_radr = (axil_req.awaddr == `GEM_REG_RADR);

  // ------------------------------------------------------------
  // write channel
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      aw_ready <= 1'b0;
      b_valid  <= 1'b0;
    end else begin
      aw_ready <= axil_req.awvalid && axil_req.wvalid && !aw_ready && !b_valid;  // pulse
      if (wr_fire)
        b_valid <= 1'b1;
      else if (axil_req.bready)
        b_valid <= 1'b0;  // held until bready
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire)
      b_resp <= (wr_ctrl || wr_radr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;  // ro offsets refuse
  end

  // ------------------------------------------------------------
  // control side effects and read address register
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      rearm         <= 1'b0;
      parity_sticky <= 1'b0;
      debug_radr    <= '0;
      debug_rsel    <= '0;
    end else begin
      rearm <= wr_fire && wr_ctrl && axil_req.wstrb[0] && axil_req.wdata[0];
      if (wr_fire && wr_ctrl && axil_req.wstrb[0] && axil_req.wdata[1])
        parity_sticky <= 1'b0;  // software clear
      else if (rd_fire && axil_req.araddr == `GEM_REG_RDATA && debug_parity_err)
        parity_sticky <= 1'b1;  // error seen on a readout
      if (wr_fire && wr_radr) begin
        if (axil_req.wstrb[0])
          debug_radr[7:0] <= axil_req.wdata[7:0];
        if (axil_req.wstrb[1])
          debug_radr[`GEM_DEBUG_ADR_BITS-1:8] <= axil_req.wdata[`GEM_DEBUG_ADR_BITS-1:8];
        if (axil_req.wstrb[2])
          debug_rsel <= axil_req.wdata[17:16];
      end
    end
  end

  // ------------------------------------------------------------
  // read channel
  // ------------------------------------------------------------
  always_comb begin
    rd_word = '0;  // unmapped and write only offsets read zero
    rd_resp = AXI_RESP_OKAY;
    case (axil_req.araddr)
      `GEM_REG_STATUS: begin
        rd_word[1:0] = capture_state;
        rd_word[8]   = parity_sticky;
      end
      `GEM_REG_RADR: begin
        rd_word[`GEM_DEBUG_ADR_BITS-1:0] = debug_radr;
        rd_word[17:16]                   = debug_rsel;
      end
      `GEM_REG_RDATA: begin
        rd_word[`GEM_CLUSTER_BITS-1:0] = debug_rdata;
        rd_word[31]                    = debug_parity_err;
      end
      default: rd_resp = AXI_RESP_SLVERR;  // ctrl and holes
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      ar_ready <= axil_req.arvalid && !ar_ready && !r_valid;  // pulse, one read in flight
      if (rd_fire)
        r_valid <= 1'b1;
      else if (axil_req.rready)
        r_valid <= 1'b0;  // held until rready
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      r_data <= rd_word;
      r_resp <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp.awready = aw_ready;
    axil_rsp.wready  = aw_ready;
    axil_rsp.bresp   = b_resp;
    axil_rsp.bvalid  = b_valid;
    axil_rsp.rdata   = r_data;
    axil_rsp.rresp   = r_resp;
    axil_rsp.rvalid  = r_valid;
    axil_rsp.arready = ar_ready;
  end

endmodule

`default_nettype wire

// File: verilog/gem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "gem_macros.svh"

module gem_top (
  input  logic                         clock,
  input  logic                         reset,
  input  gem_pkg::gem_frame_t          gem_frame,       // sampled every clock
  output gem_pkg::gem_frame_t          clusters,        // decoded frame
  output logic [`GEM_NUM_CLUSTERS-1:0] vpf,
  output logic                         nonzero,
  input  logic                         raw_wen,
  input  logic [`GEM_RAW_ADR_BITS-1:0] raw_wadr,
  input  logic [`GEM_RAW_ADR_BITS-1:0] raw_radr,
  input  gem_pkg::gem_cluster_sel_t    raw_sel,
  output gem_pkg::gem_cluster_t        raw_rdata,
  output logic                         raw_parity_err,
  input  gem_pkg::axil_req_t           axil_req,
  output gem_pkg::axil_rsp_t           axil_rsp
);

  import gem_pkg::*;

  logic                           has_data;          // decoder trigger
  capture_state_t                 capture_state;
  logic                           debug_wen;         // high only while filling
  logic [`GEM_DEBUG_ADR_BITS-1:0] debug_wadr;
  logic [`GEM_DEBUG_ADR_BITS-1:0] debug_radr;
  gem_cluster_sel_t               debug_rsel;
  gem_cluster_t                   debug_rdata;
  logic                           debug_parity_err;
  logic                           rearm;             // from ctrl register

  // ------------------------------------------------------------
  // decode, raw hits and capture path
  // ------------------------------------------------------------
  gem_frame_decoder i_decoder (
    .clock, .reset, .gem_frame, .clusters, .vpf, .has_data, .nonzero
  );

  gem_hit_ram #(.ADR_BITS(`GEM_RAW_ADR_BITS)) raw_ram (
    .clock,
    .wen        (raw_wen),
    .wadr       (raw_wadr),
    .wdata      (gem_frame),       // undecoded frame, same cycle
    .radr       (raw_radr),
    .rsel       (raw_sel),
    .rdata      (raw_rdata),
    .parity_err (raw_parity_err)
  );

  gem_capture_ctrl i_capture (
    .clock, .reset, .has_data, .rearm,
    .state (capture_state),
    .wen   (debug_wen),
    .wadr  (debug_wadr)
  );

  gem_hit_ram #(.ADR_BITS(`GEM_DEBUG_ADR_BITS)) debug_ram (
    .clock,
    .wen        (debug_wen),
    .wadr       (debug_wadr),
    .wdata      (clusters),        // decoded frame
    .radr       (debug_radr),
    .rsel       (debug_rsel),
    .rdata      (debug_rdata),
    .parity_err (debug_parity_err)
  );

  gem_csr i_csr (
    .clock, .reset, .axil_req, .axil_rsp, .capture_state,
    .debug_rdata, .debug_parity_err, .rearm, .debug_radr, .debug_rsel
  );

endmodule

`default_nettype wire

// File: test/gem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module gem_assertions (
  input logic                    clock,
  input logic                    reset,
  input gem_pkg::axil_rsp_t      axil_rsp,
  input gem_pkg::capture_state_t capture_state,
  input logic                    debug_wen,
  input logic                    raw_parity_err
);

  import gem_pkg::*;

  int unsigned failures = 0;  // failed assertion count

  // ------------------------------------------------------------
  // bus, capture and raw ram properties
  // ------------------------------------------------------------
  resp_quiet_in_reset: assert property (
    @(negedge clock) reset |-> !axil_rsp.bvalid && !axil_rsp.rvalid)  // regs settled by now
    else begin
      failures++;
      $error("bvalid or rvalid high during reset");
    end

  wen_only_filling: assert property (
    @(posedge clock) debug_wen |-> capture_state == capture_filling)
    else begin
      failures++;
      $error("debug ram written outside the filling state");
    end

  raw_parity_clean: assert property (
    @(posedge clock) disable iff (reset) !$rose(raw_parity_err))
    else begin
      failures++;
      $error("parity error on the raw hits read port");
    end

endmodule

bind gem_top gem_assertions i_assertions (
  .clock, .reset, .axil_rsp, .capture_state, .debug_wen, .raw_parity_err
);

`default_nettype wire

// File: test/gem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "gem_macros.svh"

module gem_tb;

  import gem_pkg::*;

  localparam int GOLDEN_N   = 12;                        // lines in the golden file
  localparam int FILL_N     = 1 << `GEM_DEBUG_ADR_BITS;  // entries per capture
  localparam int AXI_CYCLES = 200;                       // room for all axi traffic
  localparam int LIMIT_NS   = (GOLDEN_N + 1100 + AXI_CYCLES) * 100 * 2;

  logic                          clock;
  logic                          reset;
  gem_frame_t                    gem_frame;
  gem_frame_t                    clusters;
  logic [`GEM_NUM_CLUSTERS-1:0]  vpf;
  logic                          nonzero;
  logic                          raw_wen;
  logic [`GEM_RAW_ADR_BITS-1:0]  raw_wadr;
  logic [`GEM_RAW_ADR_BITS-1:0]  raw_radr;
  gem_cluster_sel_t              raw_sel;
  gem_cluster_t                  raw_rdata;
  logic                          raw_parity_err;
  axil_req_t                     axil_req;
  axil_rsp_t                     axil_rsp;

  logic [119:0] golden [GOLDEN_N];          // frame, expected clusters, vpf, nonzero
  logic [55:0]  fill_frames [FILL_N];       // model of the debug ram contents
  int           raw_adrs [6]   = '{0, 2047, 1, 1023, 1024, 777};
  int           sample_adr [7] = '{0, 1, 2, 255, 512, 1022, 1023};
  integer       seed;
  int           errors;
  int           checks;
  logic [31:0]  rd_data;
  logic [1:0]   resp;

  gem_top i_gem_top (
    .clock, .reset, .gem_frame, .clusters, .vpf, .nonzero, .raw_wen, .raw_wadr,
    .raw_radr, .raw_sel, .raw_rdata, .raw_parity_err, .axil_req, .axil_rsp
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: the run did not finish within %0d ns", LIMIT_NS);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // random frame with every address prefix at 11, so never a trigger
  function automatic logic [55:0] random_filler();
    logic [63:0] r;
    logic [55:0] f;
    r = {$random(seed), $random(seed)};
    f = r[55:0];
    for (int i = 0; i < `GEM_NUM_CLUSTERS; i++) begin
      f[14*i + 9 +: 2] = 2'b11;  // adr bits 10:9
    end
    return f;
  endfunction

  task automatic drive_frame(input logic [55:0] f);
    @(negedge clock);
    gem_frame = f;
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] bresp);
    @(negedge clock);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    axil_req.wvalid  = 1'b1;
    @(negedge clock);
    while (!axil_rsp.awready) @(negedge clock);
    check_value("wready with awready", 1'b1, axil_rsp.wready);
    @(negedge clock);  // handshake on the edge just passed
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) @(negedge clock);
    bresp           = axil_rsp.bresp;
    axil_req.bready = 1'b1;
    @(negedge clock);
    axil_req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] rresp);
    @(negedge clock);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    @(negedge clock);
    while (!axil_rsp.arready) @(negedge clock);
    @(negedge clock);
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) @(negedge clock);
    data            = axil_rsp.rdata;
    rresp           = axil_rsp.rresp;
    axil_req.rready = 1'b1;
    @(negedge clock);
    axil_req.rready = 1'b0;
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    int          tries;
    int          sel;
    int          afails;
    logic [31:0] radr_word;
    seed      = 43;
    errors    = 0;
    checks    = 0;
    reset     = 1'b1;
    gem_frame = '1;  // all prefixes invalid, no trigger at reset release
    raw_wen   = 1'b0;
    raw_wadr  = '0;
    raw_radr  = '0;
    raw_sel   = '0;
    axil_req  = '0;
    $readmemh("test/gem_golden.txt", golden);
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // armed and idle until a valid cluster shows up
    axi_read(`GEM_REG_STATUS, rd_data, resp);
    check_value("status after reset", capture_idle, rd_data);
    check_value("status resp", AXI_RESP_OKAY, resp);
    repeat (20) drive_frame(random_filler());
    axi_read(`GEM_REG_STATUS, rd_data, resp);
    check_value("status with invalid frames", capture_idle, rd_data);

    drive_frame(golden[7][119:64]);  // all four clusters valid
    for (int k = 0; k < FILL_N; k++) begin
      fill_frames[k] = random_filler();  // entry k is the k-th frame after the trigger
      drive_frame(fill_frames[k]);
    end
    tries   = 0;
    rd_data = '0;
    while (rd_data[1:0] != capture_full && tries < 8) begin
      axi_read(`GEM_REG_STATUS, rd_data, resp);
      tries++;
    end
    check_value("status after fill", capture_full, rd_data);

    foreach (sample_adr[i]) begin
      sel       = i % 4;
      radr_word = (sel << 16) | sample_adr[i];
      axi_write(`GEM_REG_RADR, radr_word, resp);
      check_value("radr write resp", AXI_RESP_OKAY, resp);
      axi_read(`GEM_REG_RADR, rd_data, resp);
      check_value("radr readback", radr_word, rd_data);
      check_value("radr read resp", AXI_RESP_OKAY, resp);
      axi_read(`GEM_REG_RDATA, rd_data, resp);
      check_value($sformatf("capture entry %0d cluster %0d", sample_adr[i], sel),
                  {18'b0, fill_frames[sample_adr[i]][14*sel +: 14]}, rd_data);
      check_value("rdata resp", AXI_RESP_OKAY, resp);
    end

    // response codes, ro and wo offsets refuse the wrong direction
    axi_write(`GEM_REG_RADR, 32'hFFFF_FFFF, resp);
    axi_read(`GEM_REG_RADR, rd_data, resp);
    check_value("radr unused bits", 32'h0003_03FF, rd_data);
    axi_write(`GEM_REG_STATUS, 32'h1, resp);
    check_value("status write resp", AXI_RESP_SLVERR, resp);
    axi_write(`GEM_REG_RDATA, 32'h1, resp);
    check_value("rdata write resp", AXI_RESP_SLVERR, resp);
    axi_read(`GEM_REG_CTRL, rd_data, resp);
    check_value("ctrl read resp", AXI_RESP_SLVERR, resp);
    check_value("ctrl read data", 32'h0, rd_data);

    // re-arm from full, then a second trigger
    axi_write(`GEM_REG_CTRL, 32'h1, resp);
    check_value("ctrl write resp", AXI_RESP_OKAY, resp);
    axi_read(`GEM_REG_STATUS, rd_data, resp);
    check_value("status after rearm", capture_idle, rd_data);
    repeat (20) drive_frame(random_filler());
    axi_read(`GEM_REG_STATUS, rd_data, resp);
    check_value("status rearmed, invalid frames", capture_idle, rd_data);
    drive_frame(golden[3][119:64]);  // only cluster 0 valid
    drive_frame(random_filler());
    axi_read(`GEM_REG_STATUS, rd_data, resp);
    check_value("status after second trigger", capture_filling, rd_data);
    axi_write(`GEM_REG_CTRL, 32'h3, resp);  // rearm has no effect while filling
    axi_read(`GEM_REG_STATUS, rd_data, resp);
    check_value("status rearm while filling", capture_filling, rd_data);

    // decoder, one cycle latency
    for (int i = 0; i <= GOLDEN_N; i++) begin
      @(negedge clock);
      if (i > 0) begin
        check_value($sformatf("frame %0d clusters", i - 1), golden[i-1][63:8], clusters);
        check_value($sformatf("frame %0d vpf", i - 1), golden[i-1][7:4], vpf);
        check_value($sformatf("frame %0d nonzero", i - 1), golden[i-1][0], nonzero);
      end
      if (i < GOLDEN_N)
        gem_frame = golden[i][119:64];
    end

    // raw hits ram, both ends of the address range
    for (int i = 0; i < 6; i++) begin
      @(negedge clock);
      raw_wen   = 1'b1;
      raw_wadr  = raw_adrs[i];
      gem_frame = golden[i+6][119:64];
    end
    @(negedge clock);
    raw_wen = 1'b0;
    for (int i = 0; i < 6; i++) begin
      for (int s = 0; s < `GEM_NUM_CLUSTERS; s++) begin
        @(negedge clock);
        raw_radr = raw_adrs[i];
        raw_sel  = s;
        @(negedge clock);
        check_value($sformatf("raw adr %0d cluster %0d", raw_adrs[i], s),
                    golden[i+6][64 + 14*s +: 14], raw_rdata);
        check_value("raw parity", 1'b0, raw_parity_err);
      end
    end

    afails = i_gem_top.i_assertions.failures;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
    if (errors == 0 && afails == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/gem_golden.txt
// frame (56 bits) _ expected clusters (56 bits) _ vpf (4 bits) _ nonzero (4 bits)
// cluster 0 in the low bits, prefix 11 on a pad address marks an empty cluster
00000000000000_00000000000000_F_0
FFFFFFFFFFFFFF_FFFFFFFFFFFFFF_0_1
18006001800600_18006001800600_0_1
18006001800123_18006001800123_1_1
1800600AAF0600_1800600AAF0600_2_1
18015551800600_18015551800600_4_1
E97C6001800600_E97C6001800600_8_1
1000000F7FC001_1000000F7FC001_F_1
7802000F800200_7802000F800200_5_1
E0007000554600_E0007000554600_A_1
80000000000000_80000000000000_F_1
00000000003FFF_00000000003FFF_E_1

// File: gem.f
+incdir+verilog
verilog/gem_pkg.sv
verilog/gem_frame_decoder.sv
verilog/gem_hit_ram.sv
verilog/gem_capture_ctrl.sv
verilog/gem_csr.sv
verilog/gem_top.sv
test/gem_assertions.sv
test/gem_tb.sv

// File: Bender.yml
package:
  name: gem

export_include_dirs:
  - verilog

sources:
  - verilog/gem_pkg.sv
  - verilog/gem_frame_decoder.sv
  - verilog/gem_hit_ram.sv
  - verilog/gem_capture_ctrl.sv
  - verilog/gem_csr.sv
  - verilog/gem_top.sv
  - target: test
    files:
      - test/gem_assertions.sv
      - test/gem_tb.sv
